// File: axi_lite_link_pkg.sv
////////////////////////////////////////
// Shared widths, defaults and PHY word layouts for the AXI-lite link.
// Field order inside each struct sets the bit order on the PHY.
// Both ends of the link must be built with the same package.
////////////////////////////////////////
package axi_lite_link_pkg;

  // Channel widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int RESP_W = 2;

  // Credit counters and FIFO occupancy
  localparam int CRED_W = 8;

  // Default receive depths, matching the remote side's credits
  localparam int AR_DEPTH_DEF = 8;
  localparam int AW_DEPTH_DEF = 8;
  localparam int W_DEPTH_DEF  = 16;

  // Default transmit credits
  localparam int R_CREDITS_DEF = 4;
  localparam int B_CREDITS_DEF = 4;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } w_beat_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
  } r_beat_t;

  typedef struct packed {
    logic [RESP_W-1:0] bresp;
  } b_beat_t;

  // Remote master to this slave
  typedef struct packed {
    logic    ar_push;
    addr_t   ar_data;
    logic    aw_push;
    addr_t   aw_data;
    logic    w_push;
    w_beat_t w_data;
    logic    r_credit;
    logic    b_credit;
  } rx_phy_t;

  // This slave to remote master
  typedef struct packed {
    logic    r_push;
    r_beat_t r_data;
    logic    b_push;
    b_beat_t b_data;
    logic    ar_credit;
    logic    aw_credit;
    logic    w_credit;
  } tx_phy_t;

endpackage

// File: ll_receive.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Receive FIFO for one request channel, one credit pulse per pop.
// The remote side may hold at most DEPTH credits (DEPTH up to 255).
// A push into a full FIFO is dropped. Everything flushes while offline.
////////////////////////////////////////
module ll_receive #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             link_online,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             ready,
  output logic             valid,
  output logic [WIDTH-1:0] data,
  output logic             credit
);

  localparam int CW    = axi_lite_link_pkg::CRED_W;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CW-1:0]    count;
  logic             credit_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CW'(DEPTH));
  assign do_push = push && link_online && !full;

  // Head of queue goes straight to the user side
  assign valid  = link_online && (count != '0);
  assign data   = mem[rd_ptr];
  assign do_pop = valid && ready;

  // Payload storage
  always_ff @(posedge clk_wr) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else if (!link_online) begin
      // Flush, the remote side reloads its credits too
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + CW'(do_push) - CW'(do_pop);
      // One slot freed, one credit back
      credit_q <= do_pop;
    end
  end

  // No credit leaves in the first offline cycle
  assign credit = credit_q && link_online;

endmodule

// File: ll_transmit.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Credit-gated transmit stage for one response channel.
// With no credits the local slave is held off indefinitely.
// Credits reload to INIT_CREDITS while offline.
////////////////////////////////////////
module ll_transmit #(
  parameter int WIDTH        = 34,
  parameter int INIT_CREDITS = 4
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             link_online,
  input  logic             valid,
  input  logic [WIDTH-1:0] data,
  input  logic             credit,
  output logic             ready,
  output logic             push,
  output logic [WIDTH-1:0] push_data
);

  localparam int CW = axi_lite_link_pkg::CRED_W;

  logic [CW-1:0]    cred_q;
  logic             push_q;
  logic [WIDTH-1:0] data_q;
  logic             xfer;

  // Accept only with a credit in hand
  assign ready = link_online && (cred_q != '0);
  assign xfer  = valid && ready;

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      cred_q <= CW'(INIT_CREDITS);
    end else if (!link_online) begin
      cred_q <= CW'(INIT_CREDITS);
    end else begin
      // Spend and refill may land on the same edge
      cred_q <= cred_q + CW'(credit) - CW'(xfer);
    end
  end

  ////////////////////////////////////////
  // PHY output register
  ////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      push_q <= 1'b0;
    end else begin
      push_q <= xfer;
    end
  end

  // Beat held until the next transfer
  always_ff @(posedge clk_wr) begin
    if (xfer) begin
      data_q <= data;
    end
  end

  // Keep the PHY quiet in the first offline cycle
  assign push      = push_q && link_online;
  assign push_data = data_q;

endmodule

// File: axi_lite_slave_link.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Slave side of the die-to-die AXI-lite link, single clock clk_wr.
// Depths must match the credits the remote master starts with.
// Transmit credits must match the remote receive FIFO depths.
////////////////////////////////////////
module axi_lite_slave_link #(
  parameter int AR_DEPTH  = axi_lite_link_pkg::AR_DEPTH_DEF,
  parameter int AW_DEPTH  = axi_lite_link_pkg::AW_DEPTH_DEF,
  parameter int W_DEPTH   = axi_lite_link_pkg::W_DEPTH_DEF,
  parameter int R_CREDITS = axi_lite_link_pkg::R_CREDITS_DEF,
  parameter int B_CREDITS = axi_lite_link_pkg::B_CREDITS_DEF
) (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic                                  link_online,

  // PHY side
  input  axi_lite_link_pkg::rx_phy_t            rx_phy,
  output axi_lite_link_pkg::tx_phy_t            tx_phy,

  // AR channel
  output axi_lite_link_pkg::addr_t              user_araddr,
  output logic                                  user_arvalid,
  input  logic                                  user_arready,

  // AW channel
  output axi_lite_link_pkg::addr_t              user_awaddr,
  output logic                                  user_awvalid,
  input  logic                                  user_awready,

  // W channel
  output logic [axi_lite_link_pkg::DATA_W-1:0]  user_wdata,
  output logic [axi_lite_link_pkg::STRB_W-1:0]  user_wstrb,
  output logic                                  user_wvalid,
  input  logic                                  user_wready,

  // R channel
  input  logic [axi_lite_link_pkg::DATA_W-1:0]  user_rdata,
  input  logic [axi_lite_link_pkg::RESP_W-1:0]  user_rresp,
  input  logic                                  user_rvalid,
  output logic                                  user_rready,

  // B channel
  input  logic [axi_lite_link_pkg::RESP_W-1:0]  user_bresp,
  input  logic                                  user_bvalid,
  output logic                                  user_bready
);

  localparam int ADDR_BITS = $bits(axi_lite_link_pkg::addr_t);
  localparam int W_BITS    = $bits(axi_lite_link_pkg::w_beat_t);
  localparam int R_BITS    = $bits(axi_lite_link_pkg::r_beat_t);
  localparam int B_BITS    = $bits(axi_lite_link_pkg::b_beat_t);

  axi_lite_link_pkg::w_beat_t w_beat;
  axi_lite_link_pkg::r_beat_t r_beat;

  // Beat fields to and from the AXI-lite ports
  assign user_wdata   = w_beat.wdata;
  assign user_wstrb   = w_beat.wstrb;
  assign r_beat.rdata = user_rdata;
  assign r_beat.rresp = user_rresp;

  ////////////////////////////////////////
  // Request channels, PHY to user
  ////////////////////////////////////////
  ll_receive #(.WIDTH(ADDR_BITS), .DEPTH(AR_DEPTH)) ll_receive_ar (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_online (link_online),
    .push        (rx_phy.ar_push),
    .push_data   (rx_phy.ar_data),
    .ready       (user_arready),
    .valid       (user_arvalid),
    .data        (user_araddr),
    .credit      (tx_phy.ar_credit)
  );

  ll_receive #(.WIDTH(ADDR_BITS), .DEPTH(AW_DEPTH)) ll_receive_aw (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_online (link_online),
    .push        (rx_phy.aw_push),
    .push_data   (rx_phy.aw_data),
    .ready       (user_awready),
    .valid       (user_awvalid),
    .data        (user_awaddr),
    .credit      (tx_phy.aw_credit)
  );

  ll_receive #(.WIDTH(W_BITS), .DEPTH(W_DEPTH)) ll_receive_w (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_online (link_online),
    .push        (rx_phy.w_push),
    .push_data   (rx_phy.w_data),
    .ready       (user_wready),
    .valid       (user_wvalid),
    .data        (w_beat),
    .credit      (tx_phy.w_credit)
  );

  ////////////////////////////////////////
  // Response channels, user to PHY
  ////////////////////////////////////////
  ll_transmit #(.WIDTH(R_BITS), .INIT_CREDITS(R_CREDITS)) ll_transmit_r (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_online (link_online),
    .valid       (user_rvalid),
    .data        (r_beat),
    .credit      (rx_phy.r_credit),
    .ready       (user_rready),
    .push        (tx_phy.r_push),
    .push_data   (tx_phy.r_data)
  );

  ll_transmit #(.WIDTH(B_BITS), .INIT_CREDITS(B_CREDITS)) ll_transmit_b (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_online (link_online),
    .valid       (user_bvalid),
    .data        (user_bresp),
    .credit      (rx_phy.b_credit),
    .ready       (user_bready),
    .push        (tx_phy.b_push),
    .push_data   (tx_phy.b_data)
  );

endmodule

// File: tb_checks.svh
////////////////////////////////////////
// Remote PHY model, local slave responder and value checks.
// Included inside the testbench module and uses its signals directly.
////////////////////////////////////////
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic compare_value(input string what, input logic [35:0] exp,
                             input logic [35:0] act);
  assert (exp === act) else begin
    $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
    errors++;
  end
endtask

task automatic expect_true(input string what, input logic cond, input string msg);
  assert (cond === 1'b1) else begin
    $display("%s %s: %s", cur_test, what, msg);
    errors++;
  end
endtask

// Remote master pushing one beat per cycle and never past the FIFO depth
task automatic push_requests(input bit do_addr, input bit do_w, input int beats);
  for (int i = 0; i < beats; i++) begin
    @(negedge clk);
    user_arready = next_bit();
    user_awready = next_bit();
    user_wready  = next_bit();
    if (do_addr) begin
      draw(32);
      rx_phy.ar_push = 1'b1;
      rx_phy.ar_data = rnd[31:0];
      ar_q.push_back(rnd);
      draw(32);
      rx_phy.aw_push = 1'b1;
      rx_phy.aw_data = rnd[31:0];
      aw_q.push_back(rnd);
    end
    if (do_w) begin
      draw(36);
      rx_phy.w_push = 1'b1;
      rx_phy.w_data = rnd;
      w_q.push_back(rnd);
    end
  end
  @(negedge clk);
  rx_phy.ar_push = 1'b0;
  rx_phy.aw_push = 1'b0;
  rx_phy.w_push  = 1'b0;
  // Drain with random back-pressure
  while (ar_q.size() != 0 || aw_q.size() != 0 || w_q.size() != 0) begin
    @(negedge clk);
    user_arready = next_bit();
    user_awready = next_bit();
    user_wready  = next_bit();
  end
  user_arready = 1'b0;
  user_awready = 1'b0;
  user_wready  = 1'b0;
  repeat (3) @(negedge clk);
endtask

// Local slave offering responses while the remote model returns credits
task automatic run_responder(input bit is_r, input int cycles, input int credits);
  bit acc;
  repeat (cycles) begin
    @(posedge clk);
    acc = is_r ? (user_rvalid && user_rready) : (user_bvalid && user_bready);
    @(negedge clk);
    rx_phy.r_credit = 1'b0;
    rx_phy.b_credit = 1'b0;
    if (credits > 0) begin
      if (is_r) begin
        rx_phy.r_credit = 1'b1;
      end else begin
        rx_phy.b_credit = 1'b1;
      end
      credits--;
    end
    if (is_r && (acc || !user_rvalid)) begin
      user_rvalid = (r_left > 0);
      if (r_left > 0) begin
        draw(34);
        user_rdata = rnd[33:2];
        user_rresp = rnd[1:0];
        r_left--;
      end
    end
    if (!is_r && (acc || !user_bvalid)) begin
      user_bvalid = (b_left > 0);
      if (b_left > 0) begin
        draw(2);
        user_bresp = rnd[1:0];
        b_left--;
      end
    end
  end
  rx_phy.r_credit = 1'b0;
  rx_phy.b_credit = 1'b0;
endtask

`endif

// File: tb_axi_lite_slave_link.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Testbench for the AXI-lite slave link with default parameters.
// Stimulus changes on negedge and checks sample at posedge.
////////////////////////////////////////
module tb_axi_lite_slave_link;

  // Cycle budget per test
  localparam int RESET_LEN   = 8;
  localparam int REQ_LEN     = 40;
  localparam int RESP_LEN    = 24;
  localparam int RELOAD_LEN  = 24;
  localparam int TEST_CYCLES = RESET_LEN + 2 * REQ_LEN + 2 * RESP_LEN + RELOAD_LEN;
  localparam int R_CRED = axi_lite_link_pkg::R_CREDITS_DEF;
  localparam int B_CRED = axi_lite_link_pkg::B_CREDITS_DEF;

  logic clk;
  logic rst_n;
  logic link_online;
  axi_lite_link_pkg::rx_phy_t rx_phy;
  axi_lite_link_pkg::tx_phy_t tx_phy;
  axi_lite_link_pkg::addr_t user_araddr, user_awaddr;
  logic user_arvalid, user_arready, user_awvalid, user_awready;
  logic [31:0] user_wdata, user_rdata;
  logic [3:0] user_wstrb;
  logic user_wvalid, user_wready, user_rvalid, user_rready;
  logic [1:0] user_rresp, user_bresp;
  logic user_bvalid, user_bready;

  logic [15:0] lfsr = 16'd55709;
  logic [35:0] rnd;
  logic [35:0] ar_q[$], aw_q[$], w_q[$], r_q[$], b_q[$];
  bit checks_on;
  int ar_xfers, aw_xfers, w_xfers, ar_creds, aw_creds, w_creds;
  int r_pushes, b_pushes, r_left, b_left, b_cred;
  int errors, tests, failed, err_start;
  string cur_test;

  axi_lite_slave_link dut (.*, .clk_wr(clk));

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic next_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  task automatic draw(input int n);
    rnd = '0;
    for (int i = 0; i < n; i++) begin
      rnd[i] = next_bit();
    end
  endtask

  `include "tb_checks.svh"

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != err_start) failed++;
    $display("%s: %s", cur_test, (errors == err_start) ? "pass" : "fail");
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TEST_CYCLES * 2 * 20);
    $display("Watchdog: run did not finish within its time limit");
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Protocol assertions
  ////////////////////////////////////////
  // Nothing leaves the link in reset or while offline
  offline_quiet: assert property (@(posedge clk)
      checks_on && (!rst_n || !link_online) |->
      !(user_arvalid || user_awvalid || user_wvalid || user_rready || user_bready ||
        tx_phy.r_push || tx_phy.b_push || tx_phy.ar_credit || tx_phy.aw_credit ||
        tx_phy.w_credit))
    else begin
      $display("%s: output active in reset or offline", cur_test);
      errors++;
    end

  // Head of each request FIFO held under back-pressure
  ar_stable: assert property (@(posedge clk) disable iff (!checks_on || !link_online)
      (user_arvalid && !user_arready) |=> (user_arvalid && $stable(user_araddr)))
    else begin
      $display("%s: AR beat changed under back-pressure", cur_test);
      errors++;
    end

  aw_stable: assert property (@(posedge clk) disable iff (!checks_on || !link_online)
      (user_awvalid && !user_awready) |=> (user_awvalid && $stable(user_awaddr)))
    else begin
      $display("%s: AW beat changed under back-pressure", cur_test);
      errors++;
    end

  w_stable: assert property (@(posedge clk) disable iff (!checks_on || !link_online)
      (user_wvalid && !user_wready) |=>
      (user_wvalid && $stable({user_wdata, user_wstrb})))
    else begin
      $display("%s: W beat changed under back-pressure", cur_test);
      errors++;
    end

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (checks_on && link_online) begin
      if (user_arvalid && user_arready) begin
        ar_xfers++;
        expect_true("ar", ar_q.size() != 0, "AR beat with nothing pushed");
        if (ar_q.size() != 0) compare_value("ar", ar_q.pop_front(), 36'(user_araddr));
      end
      if (user_awvalid && user_awready) begin
        aw_xfers++;
        expect_true("aw", aw_q.size() != 0, "AW beat with nothing pushed");
        if (aw_q.size() != 0) compare_value("aw", aw_q.pop_front(), 36'(user_awaddr));
      end
      if (user_wvalid && user_wready) begin
        w_xfers++;
        expect_true("w", w_q.size() != 0, "W beat with nothing pushed");
        if (w_q.size() != 0) compare_value("w", w_q.pop_front(), {user_wdata, user_wstrb});
      end
      if (tx_phy.ar_credit) ar_creds++;
      if (tx_phy.aw_credit) aw_creds++;
      if (tx_phy.w_credit) w_creds++;
      // Response beats leave one cycle after their transfer
      if (tx_phy.r_push) begin
        r_pushes++;
        expect_true("r", r_q.size() != 0, "R push without a transfer");
        if (r_q.size() != 0) compare_value("r", r_q.pop_front(), 36'(tx_phy.r_data));
      end
      if (tx_phy.b_push) begin
        b_pushes++;
        expect_true("b", b_q.size() != 0, "B push without a transfer");
        if (b_q.size() != 0) compare_value("b", b_q.pop_front(), 36'(tx_phy.b_data));
      end
      if (user_rvalid && user_rready) r_q.push_back(36'({user_rdata, user_rresp}));
      if (user_bvalid && user_bready) b_q.push_back(36'(user_bresp));
      if (b_cred == 0) expect_true("b credit", !user_bready, "bready high with no credit");
      b_cred = b_cred - int'(user_bvalid && user_bready) + int'(rx_phy.b_credit);
    end else begin
      b_cred = B_CRED;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    rst_n = 1'b0;
    link_online = 1'b0;
    rx_phy = '0;
    {user_arready, user_awready, user_wready, user_rvalid, user_bvalid} = '0;
    user_rdata = '0;
    user_rresp = '0;
    user_bresp = '0;
    start_test("reset_offline");
    @(negedge clk);
    checks_on = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    link_online = 1'b1;
    end_test();

    start_test("ar_aw_order");
    push_requests(1'b1, 1'b0, 8);
    compare_value("ar credits", 36'(ar_xfers), 36'(ar_creds));
    compare_value("aw credits", 36'(aw_xfers), 36'(aw_creds));
    compare_value("ar transfers", 36'(8), 36'(ar_xfers));
    end_test();

    start_test("w_strobe_split");
    push_requests(1'b0, 1'b1, 8);
    compare_value("w credits", 36'(w_xfers), 36'(w_creds));
    end_test();

    start_test("r_credit_limit");
    r_left = 6;
    run_responder(1'b1, 12, 0);
    compare_value("r limited", 36'(R_CRED), 36'(r_pushes));
    run_responder(1'b1, 12, 2);
    compare_value("r refilled", 36'(R_CRED + 2), 36'(r_pushes));
    end_test();

    start_test("b_path");
    b_left = 6;
    run_responder(1'b0, 12, 0);
    compare_value("b limited", 36'(B_CRED), 36'(b_pushes));
    run_responder(1'b0, 12, 2);
    compare_value("b refilled", 36'(B_CRED + 2), 36'(b_pushes));
    end_test();

    start_test("offline_reload");
    @(negedge clk);
    rx_phy.ar_push = 1'b1;
    rx_phy.ar_data = 32'hdead_0001;
    @(negedge clk);
    rx_phy.ar_push = 1'b0;
    @(negedge clk);
    link_online = 1'b0;
    repeat (3) @(negedge clk);
    link_online = 1'b1;
    repeat (3) begin
      @(negedge clk);
      expect_true("reload", !user_arvalid, "stale AR word reappeared after going offline");
    end
    r_left = R_CRED;
    run_responder(1'b1, 12, 0);
    compare_value("r reload", 36'(2 * R_CRED + 2), 36'(r_pushes));
    end_test();

    $display("tests=%0d failed=%0d errors=%0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
axi_lite_link_pkg.sv
ll_receive.sv
ll_transmit.sv
axi_lite_slave_link.sv
tb_axi_lite_slave_link.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass means the log holds the pass line
rm -f sim.log
verilator --binary --timing --assert -f flist.f \
  --top-module tb_axi_lite_slave_link -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
